// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tbIbuf
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: build.f
hw/isaPkg.sv
hw/pipePkg.sv
hw/ibufWarp.sv
hw/instrBuffer.sv
hw/issueUnit.sv
hw/ibufIssueTop.sv
sim/tbIbuf.sv

// File: hw/ibufIssueTop.sv
`timescale 1ns/1ps

module ibufIssueTop import isaPkg::*; #(
    parameter int numWarps    = 4,
    parameter int warpIdWidth = $clog2(numWarps)
) (
    input  logic                   clk,
    input  logic                   rst,

    output logic [numWarps-1:0]    fetchReq,

    input  logic                   decValid,
    input  logic [warpIdWidth-1:0] decWarpId,
    input  logic [instrWidth-1:0]  decInstr,
    input  aluOpE                  decOp,
    input  logic [regIdWidth-1:0]  decDst,
    input  logic [regIdWidth-1:0]  decSrc1,
    input  logic [regIdWidth-1:0]  decSrc2,

    input  logic [numWarps-1:0]    flushWarp,

    output logic                   ocReq,
    input  logic                   ocAck,
    output logic [warpIdWidth-1:0] ocWarpId,
    output logic [instrWidth-1:0]  ocInstr,
    output aluOpE                  ocOp,
    output logic [regIdWidth-1:0]  ocDst,
    output logic [regIdWidth-1:0]  ocSrc1,
    output logic [regIdWidth-1:0]  ocSrc2,

    output logic                   exitValid,
    output logic [warpIdWidth-1:0] exitWarpId
);

    // buffer to issue
    logic [numWarps-1:0]   ready;
    logic [numWarps-1:0]   headExit;
    logic [instrWidth-1:0] issInstr;
    aluOpE                 issOp;
    logic [regIdWidth-1:0] issDst;
    logic [regIdWidth-1:0] issSrc1;
    logic [regIdWidth-1:0] issSrc2;

    // issue to buffer
    logic [numWarps-1:0]   grant;
    logic                  pop;

    instrBuffer #(
        .numWarps    (numWarps),
        .warpIdWidth (warpIdWidth)
    ) uInstrBuffer (
        .clk       (clk),
        .rst       (rst),
        .decValid  (decValid),
        .decWarpId (decWarpId),
        .decInstr  (decInstr),
        .decOp     (decOp),
        .decDst    (decDst),
        .decSrc1   (decSrc1),
        .decSrc2   (decSrc2),
        .flushWarp (flushWarp),
        .grant     (grant),
        .pop       (pop),
        .fetchReq  (fetchReq),
        .ready     (ready),
        .headExit  (headExit),
        .issInstr  (issInstr),
        .issOp     (issOp),
        .issDst    (issDst),
        .issSrc1   (issSrc1),
        .issSrc2   (issSrc2)
    );

    issueUnit #(
        .numWarps    (numWarps),
        .warpIdWidth (warpIdWidth)
    ) uIssueUnit (
        .clk        (clk),
        .rst        (rst),
        .ready      (ready),
        .headExit   (headExit),
        .issInstr   (issInstr),
        .issOp      (issOp),
        .issDst     (issDst),
        .issSrc1    (issSrc1),
        .issSrc2    (issSrc2),
        .grant      (grant),
        .pop        (pop),
        .ocReq      (ocReq),
        .ocAck      (ocAck),
        .ocWarpId   (ocWarpId),
        .ocInstr    (ocInstr),
        .ocOp       (ocOp),
        .ocDst      (ocDst),
        .ocSrc1     (ocSrc1),
        .ocSrc2     (ocSrc2),
        .exitValid  (exitValid),
        .exitWarpId (exitWarpId)
    );

endmodule

// File: hw/ibufWarp.sv
`timescale 1ns/1ps

module ibufWarp import isaPkg::*, pipePkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // decode write
    input  logic                  push,
    input  logic [instrWidth-1:0] pushInstr,
    input  aluOpE                 pushOp,
    input  logic [regIdWidth-1:0] pushDst,
    input  logic [regIdWidth-1:0] pushSrc1,
    input  logic [regIdWidth-1:0] pushSrc2,

    // control from branch resolution and issue
    input  logic                  flush,
    input  logic                  pop,
    input  logic                  granted,

    output logic                  fetchReq,
    output logic                  ready,
    output logic                  headExit,

    // head slot
    output logic [instrWidth-1:0] headInstr,
    output aluOpE                 headOp,
    output logic [regIdWidth-1:0] headDst,
    output logic [regIdWidth-1:0] headSrc1,
    output logic [regIdWidth-1:0] headSrc2
);

    typedef logic [$clog2(slotDepth)-1:0] slotPtrT;

    // slot storage
    logic [instrWidth-1:0] instrMem [slotDepth];
    aluOpE                 opMem    [slotDepth];
    logic [regIdWidth-1:0] dstMem   [slotDepth];
    logic [regIdWidth-1:0] src1Mem  [slotDepth];
    logic [regIdWidth-1:0] src2Mem  [slotDepth];

    slotCountT count;
    slotPtrT   headPtr;
    slotPtrT   tailPtr;
    logic      fetchPend;
    logic      exited;

    // circular queue, tail follows head by count
    assign tailPtr = headPtr + slotPtrT'(count);

    // one fetch in flight at a time, so a free slot is always waiting for it
    assign fetchReq = (count < slotCountT'(slotDepth)) && !fetchPend && !exited;
    assign ready    = (count != '0);
    assign headExit = ready && (headOp == EXIT);

    assign headInstr = instrMem[headPtr];
    assign headOp    = opMem[headPtr];
    assign headDst   = dstMem[headPtr];
    assign headSrc1  = src1Mem[headPtr];
    assign headSrc2  = src2Mem[headPtr];

    //////////////////////////////
    // control
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            headPtr   <= '0;
            fetchPend <= 1'b0;
            exited    <= 1'b0;
        end else begin
            if (fetchReq) begin
                fetchPend <= 1'b1;
            end
            if (push) begin
                fetchPend <= 1'b0;
            end
            if (pop && headOp == EXIT) begin
                exited <= 1'b1;
            end
            if (pop) begin
                headPtr <= headPtr + 1'b1;
            end
            if (flush) begin
                // a granted head survives unless it leaves this cycle
                fetchPend <= 1'b0;
                count     <= (granted && !pop && count != '0) ? slotCountT'(1) : '0;
            end else begin
                count <= count + slotCountT'(push) - slotCountT'(pop);
            end
        end
    end

    // payload, written only when the decode is kept
    always_ff @(posedge clk) begin
        if (push && !flush) begin
            instrMem[tailPtr] <= pushInstr;
            opMem[tailPtr]    <= pushOp;
            dstMem[tailPtr]   <= pushDst;
            src1Mem[tailPtr]  <= pushSrc1;
            src2Mem[tailPtr]  <= pushSrc2;
        end
    end

    // decode only answers a request, so it never lands on a full warp
    assert property (@(posedge clk) disable iff (rst) push |-> count < slotCountT'(slotDepth));

    // issue only pops a warp it saw as ready
    assert property (@(posedge clk) disable iff (rst) pop |-> count != '0);

endmodule

// File: hw/instrBuffer.sv
`timescale 1ns/1ps

module instrBuffer import isaPkg::*; #(
    parameter int numWarps    = 4,
    parameter int warpIdWidth = $clog2(numWarps)
) (
    input  logic                   clk,
    input  logic                   rst,

    // shared decode port
    input  logic                   decValid,
    input  logic [warpIdWidth-1:0] decWarpId,
    input  logic [instrWidth-1:0]  decInstr,
    input  aluOpE                  decOp,
    input  logic [regIdWidth-1:0]  decDst,
    input  logic [regIdWidth-1:0]  decSrc1,
    input  logic [regIdWidth-1:0]  decSrc2,

    input  logic [numWarps-1:0]    flushWarp,

    // from the issue unit
    input  logic [numWarps-1:0]    grant,
    input  logic                   pop,

    output logic [numWarps-1:0]    fetchReq,
    output logic [numWarps-1:0]    ready,
    output logic [numWarps-1:0]    headExit,

    // head of the granted warp
    output logic [instrWidth-1:0]  issInstr,
    output aluOpE                  issOp,
    output logic [regIdWidth-1:0]  issDst,
    output logic [regIdWidth-1:0]  issSrc1,
    output logic [regIdWidth-1:0]  issSrc2
);

    logic [instrWidth-1:0] headInstr [numWarps];
    aluOpE                 headOp    [numWarps];
    logic [regIdWidth-1:0] headDst   [numWarps];
    logic [regIdWidth-1:0] headSrc1  [numWarps];
    logic [regIdWidth-1:0] headSrc2  [numWarps];

    //////////////////////////////
    // per-warp buffers
    //////////////////////////////

    for (genvar w = 0; w < numWarps; w++) begin : gWarp
        ibufWarp uWarp (
            .clk       (clk),
            .rst       (rst),
            // decode demux by warp id
            .push      (decValid && decWarpId == warpIdWidth'(w)),
            .pushInstr (decInstr),
            .pushOp    (decOp),
            .pushDst   (decDst),
            .pushSrc1  (decSrc1),
            .pushSrc2  (decSrc2),
            .flush     (flushWarp[w]),
            .pop       (pop && grant[w]),
            .granted   (grant[w]),
            .fetchReq  (fetchReq[w]),
            .ready     (ready[w]),
            .headExit  (headExit[w]),
            .headInstr (headInstr[w]),
            .headOp    (headOp[w]),
            .headDst   (headDst[w]),
            .headSrc1  (headSrc1[w]),
            .headSrc2  (headSrc2[w])
        );
    end

    // output mux, warp 0 when nothing granted
    always_comb begin
        issInstr = headInstr[0];
        issOp    = headOp[0];
        issDst   = headDst[0];
        issSrc1  = headSrc1[0];
        issSrc2  = headSrc2[0];
        for (int w = 1; w < numWarps; w++) begin
            if (grant[w]) begin
                issInstr = headInstr[w];
                issOp    = headOp[w];
                issDst   = headDst[w];
                issSrc1  = headSrc1[w];
                issSrc2  = headSrc2[w];
            end
        end
    end

    // issue unit never grants two warps at once
    assert property (@(posedge clk) disable iff (rst) $onehot0(grant));

endmodule

// File: hw/isaPkg.sv
package isaPkg;

    //////////////////////////////
    // decoded instruction fields
    //////////////////////////////

    // raw instruction word as fetched
    localparam int instrWidth = 32;

    // register index, 32 architectural registers
    localparam int regIdWidth = 5;

    // immediate field carried inside the instruction word
    localparam int immWidth = 16;

    //////////////////////////////
    // opcodes
    //////////////////////////////

    // alu, memory and branch ops seen by the issue stage
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        SHL,
        LW,
        SW,
        BEQ,
        BLT,
        // retires the warp, never reaches the operand collector
        EXIT
    } aluOpE;

endpackage

// File: hw/issueUnit.sv
`timescale 1ns/1ps

module issueUnit import isaPkg::*, pipePkg::*; #(
    parameter int numWarps    = 4,
    parameter int warpIdWidth = $clog2(numWarps)
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic [numWarps-1:0]    ready,
    input  logic [numWarps-1:0]    headExit,
    input  logic [instrWidth-1:0]  issInstr,
    input  aluOpE                  issOp,
    input  logic [regIdWidth-1:0]  issDst,
    input  logic [regIdWidth-1:0]  issSrc1,
    input  logic [regIdWidth-1:0]  issSrc2,

    output logic [numWarps-1:0]    grant,
    output logic                   pop,

    // operand collector handshake
    output logic                   ocReq,
    input  logic                   ocAck,
    output logic [warpIdWidth-1:0] ocWarpId,
    output logic [instrWidth-1:0]  ocInstr,
    output aluOpE                  ocOp,
    output logic [regIdWidth-1:0]  ocDst,
    output logic [regIdWidth-1:0]  ocSrc1,
    output logic [regIdWidth-1:0]  ocSrc2,

    output logic                   exitValid,
    output logic [warpIdWidth-1:0] exitWarpId
);

    issueStateE state;

    logic [warpIdWidth-1:0] rrPtr;
    logic [numWarps-1:0]    grantReg;
    logic                   pickValid;
    logic [warpIdWidth-1:0] pickId;
    logic [numWarps-1:0]    pickGrant;
    logic                   pickExit;

    //////////////////////////////
    // round robin pick
    //////////////////////////////

    // first ready warp after the last one granted
    always_comb begin
        int idx;
        pickValid = 1'b0;
        pickId    = '0;
        for (int k = 1; k <= numWarps; k++) begin
            idx = (int'(rrPtr) + k) % numWarps;
            if (!pickValid && ready[idx]) begin
                pickValid = 1'b1;
                pickId    = warpIdWidth'(idx);
            end
        end
    end

    assign pickGrant = pickValid ? (numWarps'(1) << pickId) : '0;
    assign pickExit  = headExit[pickId];

    // pick steers the buffer mux in idle, the held grant during req
    always_comb begin
        case (state)
            IDLE:    grant = pickGrant;
            REQ:     grant = grantReg;
            default: grant = '0;
        endcase
    end

    // exits leave straight from idle, others on ack
    assign pop = (state == IDLE && pickValid && pickExit) || (state == REQ && ocAck);

    //////////////////////////////
    // handshake fsm
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            rrPtr     <= warpIdWidth'(numWarps - 1);
            grantReg  <= '0;
            ocReq     <= 1'b0;
            exitValid <= 1'b0;
        end else begin
            exitValid <= 1'b0;
            case (state)
                IDLE: begin
                    if (pickValid) begin
                        rrPtr <= pickId;
                        if (pickExit) begin
                            exitValid <= 1'b1;
                        end else begin
                            grantReg <= pickGrant;
                            ocReq    <= 1'b1;
                            state    <= REQ;
                        end
                    end
                end
                REQ: begin
                    if (ocAck) begin
                        ocReq <= 1'b0;
                        state <= RELEASE;
                    end
                end
                RELEASE: begin
                    // wait for the collector to drop ack
                    if (!ocAck) begin
                        grantReg <= '0;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // captured once per pick, held through the whole handshake
    always_ff @(posedge clk) begin
        if (state == IDLE && pickValid) begin
            if (pickExit) begin
                exitWarpId <= pickId;
            end else begin
                ocWarpId <= pickId;
                ocInstr  <= issInstr;
                ocOp     <= issOp;
                ocDst    <= issDst;
                ocSrc1   <= issSrc1;
                ocSrc2   <= issSrc2;
            end
        end
    end

    // collector may sample on any cycle of req
    assert property (@(posedge clk) disable iff (rst)
        ocReq && $past(ocReq) |-> $stable({ocWarpId, ocInstr, ocOp, ocDst, ocSrc1, ocSrc2}));

endmodule

// File: hw/pipePkg.sv
package pipePkg;

    //////////////////////////////
    // warp buffer geometry
    //////////////////////////////

    // instruction slots per warp
    localparam int slotDepth = 2;

    // holds 0 .. slotDepth
    typedef logic [$clog2(slotDepth + 1) - 1:0] slotCountT;

    //////////////////////////////
    // issue handshake
    //////////////////////////////

    // four-phase req/ack toward the operand collector
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        RELEASE
    } issueStateE;

endpackage

// File: sim/tbIbuf.sv
`timescale 1ns/1ps

module tbIbuf import isaPkg::*; ();

    localparam int numWarps    = 4;
    localparam int warpIdWidth = $clog2(numWarps);
    localparam int target      = 200;
    localparam int cycleLimit  = 20 * target;

    logic                   clk;
    logic                   rst;
    logic [numWarps-1:0]    fetchReq;
    logic                   decValid;
    logic [warpIdWidth-1:0] decWarpId;
    logic [instrWidth-1:0]  decInstr;
    aluOpE                  decOp;
    logic [regIdWidth-1:0]  decDst;
    logic [regIdWidth-1:0]  decSrc1;
    logic [regIdWidth-1:0]  decSrc2;
    logic [numWarps-1:0]    flushWarp;
    logic                   ocReq;
    logic                   ocAck;
    logic [warpIdWidth-1:0] ocWarpId;
    logic [instrWidth-1:0]  ocInstr;
    aluOpE                  ocOp;
    logic [regIdWidth-1:0]  ocDst;
    logic [regIdWidth-1:0]  ocSrc1;
    logic [regIdWidth-1:0]  ocSrc2;
    logic                   exitValid;
    logic [warpIdWidth-1:0] exitWarpId;

    // per-warp queue of decoded {instr, op, dst, src1, src2}
    logic [50:0] sentQ [numWarps][$];

    logic [31:0] lfsrState = 32'hf871;
    int          valueErrors;
    int          otherErrors;
    int          cycles;
    int          sent;
    int          pend     [numWarps];
    int          delay    [numWarps];
    int          age      [numWarps];
    int          skips    [numWarps];
    logic        exited   [numWarps];
    logic        flushPrev[numWarps];
    logic        lastOcReq;
    logic        lastOcAck;
    logic        ackWait;
    int          ackDelay;
    logic [52:0] held;

    ibufIssueTop #(.numWarps(numWarps), .warpIdWidth(warpIdWidth)) DUT (.*);

    always #50 clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // oldest unissued instruction of warp w
    function automatic void expectIssue(input int w, output logic [31:0] eInstr,
                                        output aluOpE eOp, output logic [4:0] eDst,
                                        output logic [4:0] eSrc1, output logic [4:0] eSrc2);
        logic [50:0] e;
        e      = sentQ[w].pop_front();
        eInstr = e[50:19];
        eOp    = aluOpE'(e[18:15]);
        eDst   = e[14:10];
        eSrc1  = e[9:5];
        eSrc2  = e[4:0];
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            valueErrors++;
        end
    endtask

    // round robin lets each other warp go at most once ahead of a waiting one
    task automatic noteIssue(input int v);
        for (int w = 0; w < numWarps; w++) begin
            if (w != v && age[w] >= 4) begin
                skips[w]++;
                if (skips[w] > numWarps - 1) begin
                    $display("At %0t warp %0d was passed over too often by round robin", $time, w);
                    otherErrors++;
                end
            end
        end
        skips[v] = 0;
    endtask

    task automatic checkIssued(input int w, input string what, input logic isExit);
        logic [31:0] eInstr;
        aluOpE       eOp;
        logic [4:0]  eDst;
        logic [4:0]  eSrc1;
        logic [4:0]  eSrc2;
        if (sentQ[w].size() == 0) begin
            $display("At %0t %s for warp %0d with nothing outstanding", $time, what, w);
            otherErrors++;
        end else begin
            expectIssue(w, eInstr, eOp, eDst, eSrc1, eSrc2);
            if (isExit) begin
                checkValue("exit op", 64'(eOp), 64'(EXIT));
            end else begin
                if (eOp == EXIT) begin
                    $display("At %0t warp %0d sent an EXIT instruction to the operand collector",
                             $time, w);
                    otherErrors++;
                end
                checkValue("ocInstr", 64'(ocInstr), 64'(eInstr));
                checkValue("ocOp", 64'(ocOp), 64'(eOp));
                checkValue("ocDst", 64'(ocDst), 64'(eDst));
                checkValue("ocSrc1", 64'(ocSrc1), 64'(eSrc1));
                checkValue("ocSrc2", 64'(ocSrc2), 64'(eSrc2));
            end
            noteIssue(w);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        decValid  = 1'b0;
        decWarpId = '0;
        decInstr  = '0;
        decOp     = ADD;
        decDst    = '0;
        decSrc1   = '0;
        decSrc2   = '0;
        flushWarp = '0;
        ocAck     = 1'b0;
        lastOcReq = 1'b0;
        lastOcAck = 1'b0;
        ackWait   = 1'b0;
        ackDelay  = 0;
        held      = '0;
        for (int w = 0; w < numWarps; w++) begin
            pend[w]      = 0;
            delay[w]     = 0;
            age[w]       = 0;
            skips[w]     = 0;
            exited[w]    = 1'b0;
            flushPrev[w] = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

    ////////////////////////////////
    // models and checker
    ////////////////////////////////

    always @(posedge clk) begin
        int          flushNow;
        int          holding;
        int          busy;
        logic        stopFetch;
        logic        allExited;
        logic        sending;
        logic [31:0] r;
        logic [31:0] newInstr;
        aluOpE       newOp;
        logic [4:0]  newDst;
        logic [4:0]  newSrc1;
        logic [4:0]  newSrc2;
        if (!rst) begin
            cycles++;
            decValid  <= 1'b0;
            flushWarp <= '0;

            // operand collector side
            if (ocReq && !lastOcReq) begin
                checkIssued(int'(ocWarpId), "ocReq", 1'b0);
                held     = {ocWarpId, ocInstr, ocOp, ocDst, ocSrc1, ocSrc2};
                ackDelay = int'(takeBits(3)) % 6;
                ackWait  = 1'b1;
            end
            if (ocReq && lastOcReq) begin
                checkValue("oc fields", 64'({ocWarpId, ocInstr, ocOp, ocDst, ocSrc1, ocSrc2}),
                           64'(held));
            end
            if (!ocReq && lastOcReq) begin
                checkValue("ocAck at ocReq fall", 64'(lastOcAck), 64'(1));
            end
            lastOcReq = ocReq;
            lastOcAck = ocAck;
            if (ackWait) begin
                if (ackDelay == 0) begin
                    ocAck   <= 1'b1;
                    ackWait = 1'b0;
                end else begin
                    ackDelay--;
                end
            end else if (ocAck && !ocReq) begin
                ocAck <= 1'b0;
            end

            if (exitValid) begin
                checkIssued(int'(exitWarpId), "exitValid", 1'b1);
                exited[exitWarpId] = 1'b1;
            end

            // fetch side
            busy = 0;
            for (int w = 0; w < numWarps; w++) begin
                if (pend[w] != 0 && delay[w] > 0) begin
                    delay[w]--;
                end
                busy += pend[w];
            end
            stopFetch = (sent + busy) >= target;
            for (int w = 0; w < numWarps; w++) begin
                holding = sentQ[w].size() + ((ocReq && ocWarpId == w) ? 1 : 0);
                if (!flushPrev[w]) begin
                    if (pend[w] != 0 || holding >= 2 || exited[w]) begin
                        checkValue($sformatf("fetchReq[%0d]", w), 64'(fetchReq[w]), 64'(0));
                    end else if (fetchReq[w] && !stopFetch) begin
                        pend[w]  = 1;
                        delay[w] = int'(takeBits(2)) + 1;
                    end
                end
                if (sentQ[w].size() == 0) begin
                    age[w]   = 0;
                    skips[w] = 0;
                end else begin
                    age[w]++;
                end
            end

            // flush only while a request is held, so the granted head is known
            flushNow = -1;
            if (ocReq && !ocAck && takeBits(4) == 0) begin
                flushNow = int'(takeBits(2));
                sentQ[flushNow].delete();
                pend[flushNow]  = 0;
                age[flushNow]   = 0;
                skips[flushNow] = 0;
                flushWarp[flushNow] <= 1'b1;
            end
            for (int w = 0; w < numWarps; w++) begin
                flushPrev[w] = (w == flushNow);
            end

            // one decode per cycle on the shared port
            sending = 1'b0;
            for (int w = 0; w < numWarps; w++) begin
                if (pend[w] != 0 && delay[w] == 0 && w != flushNow && !sending) begin
                    r        = takeBits(7);
                    newInstr = takeBits(32);
                    newOp    = (r == 0) ? EXIT : aluOpE'(4'(r % 9));
                    newDst   = 5'(takeBits(5));
                    newSrc1  = 5'(takeBits(5));
                    newSrc2  = 5'(takeBits(5));
                    decValid  <= 1'b1;
                    decWarpId <= warpIdWidth'(w);
                    decInstr  <= newInstr;
                    decOp     <= newOp;
                    decDst    <= newDst;
                    decSrc1   <= newSrc1;
                    decSrc2   <= newSrc2;
                    sentQ[w].push_back({newInstr, newOp, newDst, newSrc1, newSrc2});
                    pend[w] = 0;
                    sent++;
                    sending = 1'b1;
                end
            end

            allExited = 1'b1;
            busy      = 0;
            for (int w = 0; w < numWarps; w++) begin
                allExited = allExited && exited[w];
                busy += pend[w] + sentQ[w].size();
            end
            if ((stopFetch || allExited) && busy == 0 && !ocReq && !ocAck && !decValid) begin
                $display("%0d instructions sent, %0d value errors, %0d other errors",
                         sent, valueErrors, otherErrors);
                if (valueErrors + otherErrors == 0) begin
                    $display("Simulation passed");
                end else begin
                    $display("Simulation failed");
                end
                $finish;
            end else if (cycles > cycleLimit) begin
                $display("Run did not drain within %0d cycles", cycleLimit);
                $display("Simulation failed");
                $finish;
            end
        end
    end

endmodule
